// ==== Bender.yml ====
package:
  name: router_core

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/router_pkg.sv
      - source/router_regs.sv
      - source/router_ingress.sv
      - source/router_lookup.sv
      - source/router_egress.sv
      - source/router_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/router_tb.sv

// ==== filelist.f ====
+incdir+source
source/router_pkg.sv
source/router_regs.sv
source/router_ingress.sv
source/router_lookup.sv
source/router_egress.sv
source/router_top.sv
sim/router_tb.sv

// ==== sim/router_tb.sv ====
/* Router core testbench
   Directed tests with a table model, an egress beat scoreboard and a watchdog */

`timescale 1ns/1ns

`include "router_settings.svh"

module router_tb;

    import router_pkg::*;

    localparam int NUM_ING     = `ROUTER_NUM_ING_PORTS;
    localparam int NUM_EGR     = `ROUTER_NUM_EGR_PORTS;
    localparam int DEPTH       = `ROUTER_TABLE_DEPTH;
    localparam int NUM_KEYS    = NUM_EGR * NUM_ING;
    localparam int CLK_PERIOD  = 4;
    localparam int EXP_DEPTH   = 64;
    localparam int DRAIN_LIMIT = 2000;
    // Several times the length of all tests together
    localparam int WATCHDOG_NS = 20000;

    // One expected packet for an egress and ingress port pair
    typedef struct packed {
        logic [7:0] dst;
        logic [7:0] id;
        logic [7:0] len;
    } exp_pkt_t;

    logic               core_clk;
    logic               arst_n;
    logic [NUM_ING-1:0] ing_valid;
    logic [NUM_ING-1:0] ing_ready;
    data_t              ing_data [NUM_ING];
    logic [NUM_ING-1:0] ing_last;
    logic [NUM_EGR-1:0] egr_valid;
    logic [NUM_EGR-1:0] egr_ready;
    data_t              egr_data [NUM_EGR];
    logic [NUM_EGR-1:0] egr_last;
    logic               reg_wr;
    logic               reg_rd;
    reg_addr_t          reg_addr;
    reg_data_t          reg_wdata;
    reg_data_t          reg_rdata;

    // Reference model of table, enables and counters
    bit               mdl_valid [DEPTH];
    bit [7:0]         mdl_dst [DEPTH];
    int               mdl_port [DEPTH];
    bit [NUM_ING-1:0] mdl_ing_en;
    bit [NUM_EGR-1:0] mdl_egr_en;
    int               exp_ing_cnt [NUM_ING];
    int               exp_egr_cnt [NUM_EGR];
    int               exp_miss_cnt;
    int               exp_dis_cnt;
    bit [7:0]         next_id [NUM_ING];

    // Scoreboard with one ring of expected packets per port pair
    exp_pkt_t exp_mem [NUM_KEYS][EXP_DEPTH];
    int       exp_head [NUM_KEYS];
    int       exp_tail [NUM_KEYS];
    int       outstanding;
    bit       cur_active [NUM_EGR];
    exp_pkt_t cur_pkt [NUM_EGR];
    int       cur_src [NUM_EGR];
    int       cur_idx [NUM_EGR];
    time      last_rx_time [NUM_EGR];
    time      last_tx_time;

    bit bp_mode;
    int error_count;
    int tests_passed;
    int tests_failed;

    router_top router_top_inst (
        .core_clk  ( core_clk  ),
        .arst_n    ( arst_n    ),
        .ing_valid ( ing_valid ),
        .ing_ready ( ing_ready ),
        .ing_data  ( ing_data  ),
        .ing_last  ( ing_last  ),
        .egr_valid ( egr_valid ),
        .egr_ready ( egr_ready ),
        .egr_data  ( egr_data  ),
        .egr_last  ( egr_last  ),
        .reg_wr    ( reg_wr    ),
        .reg_rd    ( reg_rd    ),
        .reg_addr  ( reg_addr  ),
        .reg_wdata ( reg_wdata ),
        .reg_rdata ( reg_rdata )
    );

    always #(CLK_PERIOD / 2) core_clk = ~core_clk;

    // Random egress stalls while back-pressure is on
    always @(posedge core_clk) begin
        if (bp_mode) begin
            egr_ready <= 4'($urandom);
        end else begin
            egr_ready <= '1;
        end
    end

    always @(posedge core_clk) begin
        for (int j = 0; j < NUM_EGR; j++) begin
            if (arst_n && egr_valid[j] && egr_ready[j]) begin
                check_beat(j, egr_data[j], egr_last[j]);
            end
        end
    end

    //////////////////////////////
    // Helpers

    task automatic log_error(input string msg);
        error_count = error_count + 1;
        $display("Error @%0t ns: %s", $time, msg);
    endtask

    // Beat word is dst, source port, packet id, beat index
    task automatic check_beat(input int j, input data_t d, input logic last);
        int    key;
        data_t want;
        key = j * NUM_ING + int'(d[23:16]);
        if (!cur_active[j]) begin
            if (d[23:16] >= NUM_ING || d[7:0] != 0 || exp_head[key] == exp_tail[key]) begin
                log_error($sformatf("unexpected beat 0x%08h at egress port %0d", d, j));
                return;
            end
            cur_pkt[j]    = exp_mem[key][exp_head[key] % EXP_DEPTH];
            exp_head[key] = exp_head[key] + 1;
            cur_active[j] = 1'b1;
            cur_src[j]    = int'(d[23:16]);
            cur_idx[j]    = 0;
        end else begin
            cur_idx[j] = cur_idx[j] + 1;
        end
        want = {cur_pkt[j].dst, 8'(cur_src[j]), cur_pkt[j].id, 8'(cur_idx[j])};
        if (d !== want) begin
            log_error($sformatf("egress port %0d got 0x%08h, expected 0x%08h", j, d, want));
        end
        if (last != (cur_idx[j] + 1 == int'(cur_pkt[j].len))) begin
            log_error($sformatf("egress port %0d last flag wrong at beat %0d", j, cur_idx[j]));
        end
        if (last) begin
            cur_active[j]   = 1'b0;
            outstanding     = outstanding - 1;
            last_rx_time[j] = $time;
        end
    endtask

    // Lowest valid matching entry wins and a miss gives -1
    function automatic int model_lookup(input bit [7:0] dst);
        for (int i = 0; i < DEPTH; i++) begin
            if (mdl_valid[i] && mdl_dst[i] == dst) begin
                return mdl_port[i];
            end
        end
        return -1;
    endfunction

    task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
        @(posedge core_clk);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge core_clk);
        reg_wr    <= 1'b0;
    endtask

    task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
        @(posedge core_clk);
        reg_rd   <= 1'b1;
        reg_addr <= addr;
        @(posedge core_clk);
        reg_rd   <= 1'b0;
        @(posedge core_clk);
        data = reg_rdata;
    endtask

    task automatic check_reg(input reg_addr_t addr, input reg_data_t expected);
        reg_data_t got;
        reg_read(addr, got);
        if (got !== expected) begin
            log_error($sformatf("register 0x%02h read 0x%08h, expected 0x%08h",
                                addr, got, expected));
        end
    endtask

    task automatic table_write(input int idx, input bit valid, input bit [7:0] dst,
                               input int port);
        reg_write(reg_addr_t'(REG_TABLE + idx), {15'b0, valid, dst, 6'b0, 2'(port)});
        mdl_valid[idx] = valid;
        mdl_dst[idx]   = dst;
        mdl_port[idx]  = port;
    endtask

    task automatic set_enables(input bit [NUM_ING-1:0] ing, input bit [NUM_EGR-1:0] egr);
        reg_write(REG_ING_EN, reg_data_t'(ing));
        reg_write(REG_EGR_EN, reg_data_t'(egr));
        mdl_ing_en = ing;
        mdl_egr_en = egr;
    endtask

    task automatic send_packet(input int p, input bit [7:0] dst, input int len);
        int         port;
        int         key;
        int         wait_cycles;
        logic [7:0] id;
        id         = next_id[p];
        next_id[p] = next_id[p] + 1;
        port       = model_lookup(dst);
        if (!mdl_ing_en[p]) begin
            exp_dis_cnt = exp_dis_cnt + 1;
        end else begin
            exp_ing_cnt[p] = exp_ing_cnt[p] + 1;
            if (port < 0) begin
                exp_miss_cnt = exp_miss_cnt + 1;
            end else if (mdl_egr_en[port]) begin
                exp_egr_cnt[port] = exp_egr_cnt[port] + 1;
                key = port * NUM_ING + p;
                exp_mem[key][exp_tail[key] % EXP_DEPTH] = {dst, id, 8'(len)};
                exp_tail[key] = exp_tail[key] + 1;
                outstanding   = outstanding + 1;
            end
        end
        @(posedge core_clk);
        for (int b = 0; b < len; b++) begin
            ing_valid[p] <= 1'b1;
            ing_data[p]  <= {dst, 8'(p), id, 8'(b)};
            ing_last[p]  <= (b == len - 1);
            wait_cycles = 0;
            @(posedge core_clk);
            while (!ing_ready[p] && wait_cycles < DRAIN_LIMIT) begin
                @(posedge core_clk);
                wait_cycles = wait_cycles + 1;
            end
            if (!ing_ready[p]) begin
                $display("Ingress port %0d was never ready, packet abandoned", p);
                error_count = error_count + 1;
                break;
            end
        end
        last_tx_time = $time;
        ing_valid[p] <= 1'b0;
        ing_last[p]  <= 1'b0;
    endtask

    task automatic send_burst(input int p, input int count);
        for (int k = 0; k < count; k++) begin
            send_packet(p, 8'((1 + $urandom_range(3)) * 16), 1 + $urandom_range(7));
        end
    endtask

    // Waits for every expected packet and idles to catch stray beats
    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (outstanding != 0 && cycles < DRAIN_LIMIT) begin
            @(posedge core_clk);
            cycles = cycles + 1;
        end
        if (outstanding != 0) begin
            $display("%0d packets never arrived at the egress ports", outstanding);
            error_count = error_count + 1;
        end
        repeat (8) @(posedge core_clk);
    endtask

    task automatic check_counters();
        for (int i = 0; i < NUM_ING; i++) begin
            check_reg(reg_addr_t'(REG_ING_CNT + i), reg_data_t'(cnt_t'(exp_ing_cnt[i])));
        end
        for (int i = 0; i < NUM_EGR; i++) begin
            check_reg(reg_addr_t'(REG_EGR_CNT + i), reg_data_t'(cnt_t'(exp_egr_cnt[i])));
        end
        check_reg(REG_MISS_CNT, reg_data_t'(cnt_t'(exp_miss_cnt)));
        check_reg(REG_DIS_CNT, reg_data_t'(cnt_t'(exp_dis_cnt)));
    endtask

    task automatic report_test(input string name, input int start_errors);
        if (error_count == start_errors) begin
            tests_passed = tests_passed + 1;
            $display("Test %s: ok", name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("Test %s: %0d errors", name, error_count - start_errors);
        end
    endtask

    //////////////////////////////
    // Tests

    task automatic test_registers();
        int start_errors;
        start_errors = error_count;
        check_reg(REG_ID, reg_data_t'(`ROUTER_MODULE_ID));
        set_enables(4'h5, 4'hA);
        check_reg(REG_ING_EN, 32'h5);
        check_reg(REG_EGR_EN, 32'hA);
        table_write(7, 1'b1, 8'hC3, 2);
        check_reg(reg_addr_t'(REG_TABLE + 7), 32'h0001_C302);
        table_write(7, 1'b0, 8'h00, 0);
        check_reg(reg_addr_t'(REG_TABLE + 7), 32'h0);
        // Holes in the map
        check_reg(8'h04, 32'h0);
        check_reg(8'h18, 32'h0);
        check_reg(8'h2A, 32'h0);
        check_reg(8'hFF, 32'h0);
        report_test("registers", start_errors);
    endtask

    task automatic test_forwarding();
        int start_errors;
        start_errors = error_count;
        set_enables(4'hF, 4'hF);
        // Egress ports run opposite to the entry index
        for (int i = 0; i < 4; i++) begin
            table_write(i, 1'b1, 8'((i + 1) * 16), 3 - i);
        end
        for (int p = 0; p < NUM_ING; p++) begin
            send_burst(p, 3);
        end
        wait_drain();
        // Single beat through the idle pipeline takes one cycle
        send_packet(1, 8'h30, 1);
        wait_drain();
        if (last_rx_time[1] - last_tx_time != CLK_PERIOD) begin
            log_error($sformatf("single-beat latency %0t ns, expected %0d ns",
                                last_rx_time[1] - last_tx_time, CLK_PERIOD));
        end
        report_test("forwarding", start_errors);
    endtask

    task automatic test_arbitration();
        int start_errors;
        start_errors = error_count;
        bp_mode = 1'b1;
        fork
            send_burst(0, 6);
            send_burst(1, 6);
            send_burst(2, 6);
            send_burst(3, 6);
        join
        wait_drain();
        bp_mode = 1'b0;
        report_test("arbitration", start_errors);
    endtask

    task automatic test_miss_priority();
        int start_errors;
        start_errors = error_count;
        // An invalid entry for 0x77 must not match
        table_write(4, 1'b0, 8'h77, 2);
        table_write(5, 1'b1, 8'h50, 3);
        table_write(6, 1'b1, 8'h50, 0);
        send_packet(0, 8'h77, 3);
        send_packet(3, 8'h77, 1);
        send_packet(2, 8'h50, 4);
        send_packet(1, 8'h50, 2);
        wait_drain();
        check_reg(REG_MISS_CNT, reg_data_t'(cnt_t'(exp_miss_cnt)));
        report_test("miss and priority", start_errors);
    endtask

    task automatic test_disabled();
        int start_errors;
        start_errors = error_count;
        set_enables(4'b1011, 4'b0111);
        send_packet(2, 8'h10, 3);
        send_packet(2, 8'h20, 1);
        send_packet(0, 8'h10, 2);    // egress 3 is off
        send_packet(1, 8'h20, 2);
        wait_drain();
        check_reg(REG_DIS_CNT, reg_data_t'(cnt_t'(exp_dis_cnt)));
        set_enables(4'hF, 4'hF);
        report_test("disabled ports", start_errors);
    endtask

    task automatic test_counters();
        int start_errors;
        start_errors = error_count;
        check_counters();
        reg_write(REG_CNT_CLR, 32'h1);
        exp_ing_cnt  = '{default: 0};
        exp_egr_cnt  = '{default: 0};
        exp_miss_cnt = 0;
        exp_dis_cnt  = 0;
        check_counters();
        report_test("counters", start_errors);
    endtask

    //////////////////////////////
    // Main sequence

    initial begin
        void'($urandom(6));
        core_clk  = 1'b0;
        arst_n    = 1'b0;
        ing_valid = '0;
        ing_last  = '0;
        ing_data  = '{default: '0};
        egr_ready = '0;
        reg_wr    = 1'b0;
        reg_rd    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        repeat (4) @(posedge core_clk);
        arst_n <= 1'b1;
        @(posedge core_clk);

        test_registers();
        test_forwarding();
        test_arbitration();
        test_miss_priority();
        test_disabled();
        test_counters();

        $display("Summary: %0d tests passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not complete within %0d ns", WATCHDOG_NS);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== source/router_egress.sv ====
/* Router egress split
   Steers tagged beats to their egress port and counts delivered packets */

`timescale 1ns/1ns

`include "router_settings.svh"

module router_egress (
    input  logic                              core_clk,
    input  logic                              arst_n,

    input  router_pkg::beat_t                 egr_bus,
    input  logic                              egr_bus_valid,
    output logic                              egr_bus_ready,

    input  logic [`ROUTER_NUM_EGR_PORTS-1:0]  egr_enable,
    input  logic                              cnt_clear,

    output logic [`ROUTER_NUM_EGR_PORTS-1:0]  egr_valid,
    output logic [`ROUTER_NUM_EGR_PORTS-1:0]  egr_last,
    output router_pkg::data_t                 egr_data [`ROUTER_NUM_EGR_PORTS],
    input  logic [`ROUTER_NUM_EGR_PORTS-1:0]  egr_ready,

    output router_pkg::cnt_t                  egr_cnt [`ROUTER_NUM_EGR_PORTS]
);

    import router_pkg::*;

    egr_port_t sel_port;
    logic      port_en;

    assign sel_port = egr_bus.egr_port;
    assign port_en  = egr_enable[sel_port];

    // Traffic for a disabled port is swallowed here
    assign egr_bus_ready = port_en ? egr_ready[sel_port] : 1'b1;

    // Payload fans out, only valid is steered
    always_comb begin
        for (int j = 0; j < `ROUTER_NUM_EGR_PORTS; j++) begin
            egr_valid[j] = egr_bus_valid && port_en && (sel_port == egr_port_t'(j));
            egr_last[j]  = egr_bus.last;
            egr_data[j]  = egr_bus.data;
        end
    end

    //////////////////////////////
    // Delivered packet counters

    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            egr_cnt <= '{default: '0};
        end else if (cnt_clear) begin
            egr_cnt <= '{default: '0};
        end else if (egr_bus_valid && port_en && egr_ready[sel_port] && egr_bus.last) begin
            egr_cnt[sel_port] <= egr_cnt[sel_port] + 1'b1;
        end
    end

endmodule

// ==== source/router_ingress.sv ====
/* Router ingress merge
   Packet-locked round-robin arbiter onto the internal bus, with drop and packet counters */

`timescale 1ns/1ns

`include "router_settings.svh"

module router_ingress (
    input  logic                              core_clk,
    input  logic                              arst_n,

    input  logic [`ROUTER_NUM_ING_PORTS-1:0]  ing_valid,
    input  logic [`ROUTER_NUM_ING_PORTS-1:0]  ing_last,
    input  router_pkg::data_t                 ing_data [`ROUTER_NUM_ING_PORTS],
    output logic [`ROUTER_NUM_ING_PORTS-1:0]  ing_ready,

    input  logic [`ROUTER_NUM_ING_PORTS-1:0]  ing_enable,
    input  logic                              cnt_clear,

    output router_pkg::beat_t                 ing_bus,
    output logic                              ing_bus_valid,
    input  logic                              ing_bus_ready,

    output router_pkg::cnt_t                  ing_cnt [`ROUTER_NUM_ING_PORTS],
    output router_pkg::cnt_t                  dis_cnt
);

    import router_pkg::*;

    localparam int NUM_PORTS = `ROUTER_NUM_ING_PORTS;

    typedef enum logic {
        ARB_IDLE,
        ARB_LOCKED
    } arb_state_e;

    arb_state_e arb_state;
    ing_port_t  grant;
    ing_port_t  last_served;
    ing_port_t  rr_idx;
    ing_port_t  rr_pick;
    logic       rr_found;
    ing_port_t  sel;
    logic       sel_active;
    logic       sel_enabled;
    logic       xfer;

    //////////////////////////////
    // Round-robin pick

    // Search starts one past the port served last
    always_comb begin
        rr_pick  = last_served;
        rr_found = 1'b0;
        for (int k = 1; k <= NUM_PORTS; k++) begin
            rr_idx = ing_port_t'((int'(last_served) + k) % NUM_PORTS);
            if (!rr_found && ing_valid[rr_idx]) begin
                rr_pick  = rr_idx;
                rr_found = 1'b1;
            end
        end
    end

    // Idle picks pass through in the same cycle
    assign sel         = (arb_state == ARB_LOCKED) ? grant : rr_pick;
    assign sel_active  = (arb_state == ARB_LOCKED) || rr_found;
    assign sel_enabled = ing_enable[sel];
    assign xfer        = sel_active && ing_valid[sel] && (!sel_enabled || ing_bus_ready);

    // Disabled port is always ready so its beats drain away
    always_comb begin
        ing_ready      = '0;
        ing_ready[sel] = sel_active && (!sel_enabled || ing_bus_ready);
    end

    assign ing_bus_valid    = sel_active && ing_valid[sel] && sel_enabled;
    assign ing_bus.data     = ing_data[sel];
    assign ing_bus.last     = ing_last[sel];
    assign ing_bus.ing_port = sel;
    assign ing_bus.egr_port = '0;

    //////////////////////////////
    // Arbiter FSM

    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            arb_state   <= ARB_IDLE;
            grant       <= '0;
            last_served <= ing_port_t'(NUM_PORTS - 1);
        end else if (xfer) begin
            if (ing_last[sel]) begin
                arb_state   <= ARB_IDLE;
                last_served <= sel;
            end else begin
                arb_state <= ARB_LOCKED;
                grant     <= sel;
            end
        end
    end

    //////////////////////////////
    // Counters

    // Forwarded packets per port, discarded ones in dis_cnt
    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            ing_cnt <= '{default: '0};
            dis_cnt <= '0;
        end else if (cnt_clear) begin
            ing_cnt <= '{default: '0};
            dis_cnt <= '0;
        end else if (xfer && ing_last[sel]) begin
            if (sel_enabled) begin
                ing_cnt[sel] <= ing_cnt[sel] + 1'b1;
            end else begin
                dis_cnt <= dis_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== source/router_lookup.sv ====
/* Router lookup stage
   Matches each packet's destination byte in the table and tags the egress port */

`timescale 1ns/1ns

`include "router_settings.svh"

module router_lookup (
    input  logic                      core_clk,
    input  logic                      arst_n,

    input  router_pkg::beat_t         ing_bus,
    input  logic                      ing_bus_valid,
    output logic                      ing_bus_ready,

    input  router_pkg::table_entry_t  lookup_table [`ROUTER_TABLE_DEPTH],
    input  logic                      cnt_clear,

    output router_pkg::beat_t         egr_bus,
    output logic                      egr_bus_valid,
    input  logic                      egr_bus_ready,

    output router_pkg::cnt_t          miss_cnt
);

    import router_pkg::*;

    dst_addr_t dst;
    logic      hit;
    egr_port_t hit_port;
    logic      in_sop;
    egr_port_t pkt_port;
    logic      pkt_drop;
    egr_port_t cur_port;
    logic      cur_drop;
    logic      accept;

    assign ing_bus_ready = !egr_bus_valid || egr_bus_ready;
    assign accept        = ing_bus_valid && ing_bus_ready;

    //////////////////////////////
    // Table match

    assign dst = ing_bus.data[`ROUTER_DATA_WIDTH-1 -: $bits(dst_addr_t)];

    // Scan downwards so the lowest index wins
    always_comb begin
        hit      = 1'b0;
        hit_port = '0;
        for (int i = `ROUTER_TABLE_DEPTH - 1; i >= 0; i--) begin
            if (lookup_table[i].valid && (lookup_table[i].dst == dst)) begin
                hit      = 1'b1;
                hit_port = lookup_table[i].port;
            end
        end
    end

    // First beat decides, later beats reuse the held result
    assign cur_port = in_sop ? hit_port : pkt_port;
    assign cur_drop = in_sop ? !hit : pkt_drop;

    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            in_sop   <= 1'b1;
            pkt_port <= '0;
            pkt_drop <= 1'b0;
        end else if (accept) begin
            in_sop   <= ing_bus.last;
            pkt_port <= cur_port;
            pkt_drop <= cur_drop;
        end
    end

    //////////////////////////////
    // Output register

    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            egr_bus_valid <= 1'b0;
        end else if (accept && !cur_drop) begin
            egr_bus_valid <= 1'b1;
        end else if (egr_bus_ready) begin
            egr_bus_valid <= 1'b0;
        end
    end

    always_ff @(posedge core_clk) begin
        if (accept && !cur_drop) begin
            egr_bus          <= ing_bus;
            egr_bus.egr_port <= cur_port;
        end
    end

    // One count per missed packet
    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            miss_cnt <= '0;
        end else if (cnt_clear) begin
            miss_cnt <= '0;
        end else if (accept && in_sop && !hit) begin
            miss_cnt <= miss_cnt + 1'b1;
        end
    end

endmodule

// ==== source/router_pkg.sv ====
/* Router types
   Vector types, the internal beat struct and the register map */

`include "router_settings.svh"

package router_pkg;

    //////////////////////////////
    // Vector types

    typedef logic [`ROUTER_DATA_WIDTH-1:0]              data_t;
    typedef logic [$clog2(`ROUTER_NUM_ING_PORTS)-1:0]   ing_port_t;
    typedef logic [$clog2(`ROUTER_NUM_EGR_PORTS)-1:0]   egr_port_t;
    typedef logic [7:0]                                 dst_addr_t;
    typedef logic [`ROUTER_CNT_WIDTH-1:0]               cnt_t;
    typedef logic [7:0]                                 reg_addr_t;
    typedef logic [31:0]                                reg_data_t;

    //////////////////////////////
    // Structs

    // One beat on the internal buses, with source and destination port
    typedef struct packed {
        data_t      data;
        logic       last;
        ing_port_t  ing_port;
        egr_port_t  egr_port;
    } beat_t;

    typedef struct packed {
        logic       valid;
        dst_addr_t  dst;
        egr_port_t  port;
    } table_entry_t;

    //////////////////////////////
    // Register map

    typedef enum logic [7:0] {
        REG_ID       = 8'h00,
        REG_ING_EN   = 8'h01,
        REG_EGR_EN   = 8'h02,
        REG_CNT_CLR  = 8'h03,
        REG_TABLE    = 8'h10,
        REG_ING_CNT  = 8'h20,
        REG_EGR_CNT  = 8'h24,
        REG_MISS_CNT = 8'h28,
        REG_DIS_CNT  = 8'h29
    } reg_map_e;

endpackage

// ==== source/router_regs.sv ====
/* Router register block
   Port enables, table entries, counter clear and counter read-back */

`timescale 1ns/1ns

`include "router_settings.svh"

module router_regs (
    input  logic                              core_clk,
    input  logic                              arst_n,

    input  logic                              reg_wr,
    input  logic                              reg_rd,
    input  router_pkg::reg_addr_t             reg_addr,
    input  router_pkg::reg_data_t             reg_wdata,
    output router_pkg::reg_data_t             reg_rdata,

    output logic [`ROUTER_NUM_ING_PORTS-1:0]  ing_enable,
    output logic [`ROUTER_NUM_EGR_PORTS-1:0]  egr_enable,
    output router_pkg::table_entry_t          lookup_table [`ROUTER_TABLE_DEPTH],
    output logic                              cnt_clear,

    input  router_pkg::cnt_t                  ing_cnt [`ROUTER_NUM_ING_PORTS],
    input  router_pkg::cnt_t                  egr_cnt [`ROUTER_NUM_EGR_PORTS],
    input  router_pkg::cnt_t                  miss_cnt,
    input  router_pkg::cnt_t                  dis_cnt
);

    import router_pkg::*;

    reg_data_t rd_mux;

    //////////////////////////////
    // Write decode

    // Any write to the clear address clears on the same edge
    assign cnt_clear = reg_wr && (reg_addr == REG_CNT_CLR);

    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            ing_enable   <= '0;
            egr_enable   <= '0;
            lookup_table <= '{default: '0};
        end else if (reg_wr) begin
            case (reg_addr)
                REG_ING_EN: ing_enable <= reg_wdata[`ROUTER_NUM_ING_PORTS-1:0];
                REG_EGR_EN: egr_enable <= reg_wdata[`ROUTER_NUM_EGR_PORTS-1:0];
                default: ;
            endcase
            // Entry layout is valid at 16, dst at 15:8, port at 1:0
            for (int i = 0; i < `ROUTER_TABLE_DEPTH; i++) begin
                if (reg_addr == reg_addr_t'(REG_TABLE + i)) begin
                    lookup_table[i].valid <= reg_wdata[16];
                    lookup_table[i].dst   <= reg_wdata[15:8];
                    lookup_table[i].port  <= reg_wdata[$bits(egr_port_t)-1:0];
                end
            end
        end
    end

    //////////////////////////////
    // Read mux

    always_comb begin
        rd_mux = '0;
        case (reg_addr)
            REG_ID:       rd_mux = reg_data_t'(`ROUTER_MODULE_ID);
            REG_ING_EN:   rd_mux = reg_data_t'(ing_enable);
            REG_EGR_EN:   rd_mux = reg_data_t'(egr_enable);
            REG_MISS_CNT: rd_mux = reg_data_t'(miss_cnt);
            REG_DIS_CNT:  rd_mux = reg_data_t'(dis_cnt);
            default: ;
        endcase
        for (int i = 0; i < `ROUTER_TABLE_DEPTH; i++) begin
            if (reg_addr == reg_addr_t'(REG_TABLE + i)) begin
                rd_mux[16]   = lookup_table[i].valid;
                rd_mux[15:8] = lookup_table[i].dst;
                rd_mux[$bits(egr_port_t)-1:0] = lookup_table[i].port;
            end
        end
        for (int i = 0; i < `ROUTER_NUM_ING_PORTS; i++) begin
            if (reg_addr == reg_addr_t'(REG_ING_CNT + i)) begin
                rd_mux = reg_data_t'(ing_cnt[i]);
            end
        end
        for (int i = 0; i < `ROUTER_NUM_EGR_PORTS; i++) begin
            if (reg_addr == reg_addr_t'(REG_EGR_CNT + i)) begin
                rd_mux = reg_data_t'(egr_cnt[i]);
            end
        end
    end

    // Read data holds until the next read strobe
    always_ff @(posedge core_clk) begin
        if (reg_rd) begin
            reg_rdata <= rd_mux;
        end
    end

endmodule

// ==== source/router_settings.svh ====
/* Router core settings
   Port counts, stream width, table depth, counter width and module ID */

`ifndef ROUTER_SETTINGS_SVH
`define ROUTER_SETTINGS_SVH

// Port counts
`define ROUTER_NUM_ING_PORTS 4
`define ROUTER_NUM_EGR_PORTS 4

// Beat width in bits
`define ROUTER_DATA_WIDTH 32

// Match-action table entries
`define ROUTER_TABLE_DEPTH 8

// Every counter wraps at this width
`define ROUTER_CNT_WIDTH 16

// Read back at register 0
`define ROUTER_MODULE_ID 16'h0A41

`endif

// ==== source/router_top.sv ====
/* Router core top level
   Register block around the ingress merge, lookup and egress split */

`timescale 1ns/1ns

`include "router_settings.svh"

module router_top (
    input  logic                              core_clk,
    input  logic                              arst_n,

    input  logic [`ROUTER_NUM_ING_PORTS-1:0]  ing_valid,
    output logic [`ROUTER_NUM_ING_PORTS-1:0]  ing_ready,
    input  router_pkg::data_t                 ing_data [`ROUTER_NUM_ING_PORTS],
    input  logic [`ROUTER_NUM_ING_PORTS-1:0]  ing_last,

    output logic [`ROUTER_NUM_EGR_PORTS-1:0]  egr_valid,
    input  logic [`ROUTER_NUM_EGR_PORTS-1:0]  egr_ready,
    output router_pkg::data_t                 egr_data [`ROUTER_NUM_EGR_PORTS],
    output logic [`ROUTER_NUM_EGR_PORTS-1:0]  egr_last,

    input  logic                              reg_wr,
    input  logic                              reg_rd,
    input  router_pkg::reg_addr_t             reg_addr,
    input  router_pkg::reg_data_t             reg_wdata,
    output router_pkg::reg_data_t             reg_rdata
);

    import router_pkg::*;

    //////////////////////////////
    // Control and counters

    logic [`ROUTER_NUM_ING_PORTS-1:0] ing_enable;
    logic [`ROUTER_NUM_EGR_PORTS-1:0] egr_enable;
    table_entry_t                     lookup_table [`ROUTER_TABLE_DEPTH];
    logic                             cnt_clear;
    cnt_t                             ing_cnt [`ROUTER_NUM_ING_PORTS];
    cnt_t                             egr_cnt [`ROUTER_NUM_EGR_PORTS];
    cnt_t                             miss_cnt;
    cnt_t                             dis_cnt;

    // Internal buses
    beat_t ing_bus;
    logic  ing_bus_valid;
    logic  ing_bus_ready;
    beat_t egr_bus;
    logic  egr_bus_valid;
    logic  egr_bus_ready;

    router_regs regs_inst (
        .core_clk     ( core_clk     ),
        .arst_n       ( arst_n       ),
        .reg_wr       ( reg_wr       ),
        .reg_rd       ( reg_rd       ),
        .reg_addr     ( reg_addr     ),
        .reg_wdata    ( reg_wdata    ),
        .reg_rdata    ( reg_rdata    ),
        .ing_enable   ( ing_enable   ),
        .egr_enable   ( egr_enable   ),
        .lookup_table ( lookup_table ),
        .cnt_clear    ( cnt_clear    ),
        .ing_cnt      ( ing_cnt      ),
        .egr_cnt      ( egr_cnt      ),
        .miss_cnt     ( miss_cnt     ),
        .dis_cnt      ( dis_cnt      )
    );

    //////////////////////////////
    // Datapath

    router_ingress ingress_inst (
        .core_clk      ( core_clk      ),
        .arst_n        ( arst_n        ),
        .ing_valid     ( ing_valid     ),
        .ing_last      ( ing_last      ),
        .ing_data      ( ing_data      ),
        .ing_ready     ( ing_ready     ),
        .ing_enable    ( ing_enable    ),
        .cnt_clear     ( cnt_clear     ),
        .ing_bus       ( ing_bus       ),
        .ing_bus_valid ( ing_bus_valid ),
        .ing_bus_ready ( ing_bus_ready ),
        .ing_cnt       ( ing_cnt       ),
        .dis_cnt       ( dis_cnt       )
    );

    router_lookup lookup_inst (
        .core_clk      ( core_clk      ),
        .arst_n        ( arst_n        ),
        .ing_bus       ( ing_bus       ),
        .ing_bus_valid ( ing_bus_valid ),
        .ing_bus_ready ( ing_bus_ready ),
        .lookup_table  ( lookup_table  ),
        .cnt_clear     ( cnt_clear     ),
        .egr_bus       ( egr_bus       ),
        .egr_bus_valid ( egr_bus_valid ),
        .egr_bus_ready ( egr_bus_ready ),
        .miss_cnt      ( miss_cnt      )
    );

    router_egress egress_inst (
        .core_clk      ( core_clk      ),
        .arst_n        ( arst_n        ),
        .egr_bus       ( egr_bus       ),
        .egr_bus_valid ( egr_bus_valid ),
        .egr_bus_ready ( egr_bus_ready ),
        .egr_enable    ( egr_enable    ),
        .cnt_clear     ( cnt_clear     ),
        .egr_valid     ( egr_valid     ),
        .egr_last      ( egr_last      ),
        .egr_data      ( egr_data      ),
        .egr_ready     ( egr_ready     ),
        .egr_cnt       ( egr_cnt       )
    );

endmodule
